/* logic/bfm_pkg.sv */
/*
 * internal work package
 * memory write pairs from the parser and pending read jobs
 * handed to the completion builder
 */
`include "tlbfm_settings.svh"

package bfm_pkg;

   // dword pair write, slot k lands at base+k modulo memory size
   typedef struct packed {
      logic [`TLBFM_MEM_AW-1:0] base;
      logic [1:0]               dw_en;  // bit k enables slot k
      logic [63:0]              data;   // slot 0 in the low dword
   } mem_wr_t;

   // one read waiting for its completion
   typedef struct packed {
      logic [15:0]              requester_id;
      logic [7:0]               tag;
      logic [3:0]               length;      // 1 to max payload
      logic [`TLBFM_MEM_AW-1:0] index;       // first dword
      logic [6:0]               lower_addr;
   } cpl_job_t;

endpackage

/* logic/bfm_shmem.sv */
/*
 * shared dword memory
 * one dword pair write port and one registered dword pair read port,
 * both indexed modulo the memory size
 */
`timescale 1ns/10ps
`include "tlbfm_settings.svh"

module bfm_shmem (
   input  logic                     avst64_clk,
   input  bfm_pkg::mem_wr_t         mem_wr,
   input  logic                     mem_wr_valid,
   input  logic [`TLBFM_MEM_AW-1:0] rd_index,
   output logic [63:0]              rd_data
);
   localparam int aw = `TLBFM_MEM_AW;

   logic [31:0]   mem [1 << aw];
   logic [aw-1:0] wr_hi_idx;
   logic [aw-1:0] rd_hi_idx;

   assign wr_hi_idx = mem_wr.base + 1'b1;  // wraps past the top
   assign rd_hi_idx = rd_index + 1'b1;

   always_ff @(posedge avst64_clk) begin
      if (mem_wr_valid) begin
         if (mem_wr.dw_en[0]) mem[mem_wr.base] <= mem_wr.data[31:0];
         if (mem_wr.dw_en[1]) mem[wr_hi_idx]   <= mem_wr.data[63:32];
      end
      rd_data <= {mem[rd_hi_idx], mem[rd_index]};  // index in the low dword
   end

endmodule

/* logic/cpl_tx_builder.sv */
/*
 * completion builder
 * pops read jobs, forms the completion header and streams header and
 * memory data as 64-bit beats, fetching one beat ahead and holding
 * under back-pressure
 */
`timescale 1ns/10ps
`include "tlbfm_settings.svh"

module cpl_tx_builder (
   input  logic                     avst64_clk,
   input  logic                     bfm_reset_n,
   input  bfm_pkg::cpl_job_t        job,
   input  logic                     job_valid,
   output logic                     job_ready,
   output logic [`TLBFM_MEM_AW-1:0] rd_index,
   input  logic [63:0]              rd_data,
   output tlp_pkg::avst_beat_t      tx_beat,
   output logic                     tx_valid,
   input  logic                     tx_ready
);
   localparam int aw = `TLBFM_MEM_AW;

   bfm_pkg::cpl_job_t job_q;
   logic              busy;        // beats of job_q still to fetch
   logic [2:0]        cnt;         // next beat to fetch
   logic [4:0]        n_beats;
   logic [2:0]        last_k;
   logic              issue;
   logic              advance;
   logic [aw-1:0]     next_idx;
   logic [31:0]       dw0;
   logic [31:0]       dw1;
   logic [31:0]       dw2;

   // fetch stage, rd_data belongs to it
   logic              f_valid;
   logic [aw-1:0]     f_idx;
   logic              f_sop;
   logic              f_mix;       // dword 2 low, data 0 high
   logic              f_eop;
   logic              f_empty;
   logic [63:0]       f_hdr;

   //--------------------------------------------------------------------
   // header dwords
   //--------------------------------------------------------------------
   assign dw0 = {tlp_pkg::fmt_cpld, 14'h0, 6'h0, job_q.length};
   assign dw1 = {`TLBFM_CPL_ID, 3'b000, 1'b0, 6'h0, job_q.length, 2'b00};  // bytes = len*4
   assign dw2 = {job_q.requester_id, job_q.tag, 1'b0, job_q.lower_addr};

   assign n_beats = (5'(job_q.length) + 5'd4) >> 1;  // ceil((3+len)/2)
   assign last_k  = n_beats[2:0] - 3'd1;

   // beat k>=1 reads from index+2k-3 so data sits high for beat 1
   assign next_idx = job_q.index + aw'({cnt, 1'b0}) - aw'(3);

   assign job_ready = ~busy;
   assign advance   = f_valid & (~tx_valid | tx_ready);
   assign issue     = busy & (~f_valid | advance);
   assign rd_index  = issue ? next_idx : f_idx;  // stalled stage rereads its own pair

   always_ff @(posedge avst64_clk or negedge bfm_reset_n) begin
      if (!bfm_reset_n) begin
         busy     <= 1'b0;
         cnt      <= '0;
         f_valid  <= 1'b0;
         tx_valid <= 1'b0;
      end else begin
         if (job_valid & job_ready) begin
            busy <= 1'b1;
            cnt  <= '0;
         end else if (issue) begin
            cnt <= cnt + 3'd1;
            if (cnt == last_k) busy <= 1'b0;   // next job may load now
         end
         if (issue)        f_valid <= 1'b1;
         else if (advance) f_valid <= 1'b0;
         if (advance)       tx_valid <= 1'b1;
         else if (tx_ready) tx_valid <= 1'b0;
      end
   end

   //--------------------------------------------------------------------
   // job, fetch stage and output beat
   //--------------------------------------------------------------------
   always_ff @(posedge avst64_clk) begin
      if (job_valid & job_ready) job_q <= job;
      if (issue) begin
         f_idx   <= next_idx;
         f_sop   <= (cnt == 3'd0);
         f_mix   <= (cnt == 3'd1);
         f_eop   <= (cnt == last_k);
         f_empty <= (cnt == last_k) & ~job_q.length[0];  // 3+len odd
         f_hdr   <= (cnt == 3'd0) ? {dw1, dw0} : {32'h0, dw2};  // header kept past job_q reload
      end
      if (advance) begin
         if (f_sop)      tx_beat.data <= f_hdr;
         else if (f_mix) tx_beat.data <= {rd_data[63:32], f_hdr[31:0]};
         else            tx_beat.data <= rd_data;
         tx_beat.sop   <= f_sop;
         tx_beat.eop   <= f_eop;
         tx_beat.empty <= f_empty;
      end
   end

endmodule

/* logic/tlbfm_rp.sv */
/*
 * TL BFM root port responder top
 * beat buffer and parser on the receive side, shared memory,
 * read-job queue and completion builder on the transmit side
 */
`timescale 1ns/10ps
`include "tlbfm_settings.svh"

module tlbfm_rp (
   input  logic                avst64_clk,
   input  logic                bfm_reset_n,
   input  tlp_pkg::avst_beat_t rx_beat,
   input  logic                rx_valid,
   output logic                rx_ready,
   output tlp_pkg::avst_beat_t tx_beat,
   output logic                tx_valid,
   input  logic                tx_ready,
   output logic [15:0]         tlp_drop_count
);
   tlp_pkg::avst_beat_t      buf_beat;     // beat buffer to parser
   logic                     buf_valid;
   logic                     buf_ready;
   bfm_pkg::mem_wr_t         mem_wr;
   logic                     mem_wr_valid;
   bfm_pkg::cpl_job_t        new_job;      // parser to job queue
   logic                     new_job_valid;
   logic                     new_job_ready;
   bfm_pkg::cpl_job_t        cpl_job;      // job queue to builder
   logic                     cpl_job_valid;
   logic                     cpl_job_ready;
   logic [`TLBFM_MEM_AW-1:0] rd_index;
   logic [63:0]              rd_data;

   //--------------------------------------------------------------------
   // receive side
   //--------------------------------------------------------------------
   tlp_fifo #(
      .payload_t (tlp_pkg::avst_beat_t),
      .depth_aw  (`TLBFM_RX_FIFO_AW)
   ) u_rx_fifo (
      .avst64_clk  (avst64_clk),
      .bfm_reset_n (bfm_reset_n),
      .in_data     (rx_beat),
      .in_valid    (rx_valid),
      .in_ready    (rx_ready),
      .out_data    (buf_beat),
      .out_valid   (buf_valid),
      .out_ready   (buf_ready)
   );

   tlp_rx_parser u_parser (
      .avst64_clk     (avst64_clk),
      .bfm_reset_n    (bfm_reset_n),
      .beat           (buf_beat),
      .beat_valid     (buf_valid),
      .beat_ready     (buf_ready),
      .mem_wr         (mem_wr),
      .mem_wr_valid   (mem_wr_valid),
      .job            (new_job),
      .job_valid      (new_job_valid),
      .job_ready      (new_job_ready),
      .tlp_drop_count (tlp_drop_count)
   );

   //--------------------------------------------------------------------
   // memory and transmit side
   //--------------------------------------------------------------------
   tlp_fifo #(
      .payload_t (bfm_pkg::cpl_job_t),
      .depth_aw  (`TLBFM_RD_FIFO_AW)
   ) u_rd_fifo (
      .avst64_clk  (avst64_clk),
      .bfm_reset_n (bfm_reset_n),
      .in_data     (new_job),
      .in_valid    (new_job_valid),
      .in_ready    (new_job_ready),
      .out_data    (cpl_job),
      .out_valid   (cpl_job_valid),
      .out_ready   (cpl_job_ready)
   );

   bfm_shmem u_shmem (
      .avst64_clk   (avst64_clk),
      .mem_wr       (mem_wr),
      .mem_wr_valid (mem_wr_valid),
      .rd_index     (rd_index),
      .rd_data      (rd_data)
   );

   cpl_tx_builder u_builder (
      .avst64_clk  (avst64_clk),
      .bfm_reset_n (bfm_reset_n),
      .job         (cpl_job),
      .job_valid   (cpl_job_valid),
      .job_ready   (cpl_job_ready),
      .rd_index    (rd_index),
      .rd_data     (rd_data),
      .tx_beat     (tx_beat),
      .tx_valid    (tx_valid),
      .tx_ready    (tx_ready)
   );

endmodule

/* logic/tlbfm_settings.svh */
/*
 * TL BFM root port settings
 * sizes, depths and IDs shared by the RTL and the testbench
 */
`ifndef TLBFM_SETTINGS_SVH
`define TLBFM_SETTINGS_SVH

`define TLBFM_MEM_AW       6        // dword address bits, 64 dwords of shared memory
`define TLBFM_RX_FIFO_AW   2        // beat buffer holds 4 beats
`define TLBFM_RD_FIFO_AW   2        // read-job queue holds 4 jobs
`define TLBFM_MAX_PAYLOAD  8        // largest length field accepted, in dwords
`define TLBFM_CPL_ID       16'h0100 // completer ID of the root port

`endif

/* logic/tlp_fifo.sv */
/*
 * synchronous FIFO
 * circular buffer with valid/ready on both sides, one cycle from push
 * to pop valid, payload type given by parameter
 */
`timescale 1ns/10ps

module tlp_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  depth_aw  = 2
) (
   input  logic     avst64_clk,
   input  logic     bfm_reset_n,
   input  payload_t in_data,
   input  logic     in_valid,
   output logic     in_ready,
   output payload_t out_data,
   output logic     out_valid,
   input  logic     out_ready
);
   localparam int depth = 1 << depth_aw;

   payload_t            store [depth];
   logic [depth_aw-1:0] wr_ptr;
   logic [depth_aw-1:0] rd_ptr;
   logic [depth_aw:0]   fill;      // top bit set only when full
   logic [depth_aw:0]   fill_nxt;
   logic                push;
   logic                pop;

   assign push      = in_valid & in_ready;
   assign pop       = out_valid & out_ready;
   assign out_valid = (fill != '0);
   assign out_data  = store[rd_ptr];

   always_comb begin
      fill_nxt = fill;
      if (push & ~pop)
         fill_nxt = fill + 1'b1;
      else if (pop & ~push)
         fill_nxt = fill - 1'b1;
   end

   always_ff @(posedge avst64_clk or negedge bfm_reset_n) begin
      if (!bfm_reset_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         fill     <= '0;
         in_ready <= 1'b0;  // rises on the first edge after reset
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;   // pointers wrap on their own
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         fill     <= fill_nxt;
         in_ready <= ~fill_nxt[depth_aw];
      end
   end

   always_ff @(posedge avst64_clk) begin
      if (push) store[wr_ptr] <= in_data;
   end

endmodule

/* logic/tlp_pkg.sv */
/*
 * link format package
 * packet type codes and the 64-bit Avalon-ST beat, plus the decoded
 * 3-DW request header
 */
package tlp_pkg;

   // header byte 0 values
   localparam logic [7:0] fmt_mwr32 = 8'h40;  // memory write, 3-DW, with data
   localparam logic [7:0] fmt_mrd32 = 8'h00;  // memory read, 3-DW
   localparam logic [7:0] fmt_cpld  = 8'h4A;  // completion with data

   // one stream beat
   typedef struct packed {
      logic [63:0] data;   // lower dword goes first on the wire
      logic        sop;
      logic        eop;
      logic        empty;  // upper dword unused
   } avst_beat_t;

   // decoded request header
   typedef struct packed {
      logic [7:0]  fmt_type;
      logic [9:0]  length;        // dwords, 0 means 1024
      logic [15:0] requester_id;
      logic [7:0]  tag;
      logic [31:0] address;       // byte address
   } tlp_hdr_t;

endpackage

/* logic/tlp_rx_parser.sv */
/*
 * request parser
 * decodes 3-DW headers from the beat stream, turns write payload into
 * dword pair writes and read headers into completion jobs, drops and
 * counts anything else
 */
`timescale 1ns/10ps
`include "tlbfm_settings.svh"

module tlp_rx_parser (
   input  logic                avst64_clk,
   input  logic                bfm_reset_n,
   input  tlp_pkg::avst_beat_t beat,
   input  logic                beat_valid,
   output logic                beat_ready,
   output bfm_pkg::mem_wr_t    mem_wr,
   output logic                mem_wr_valid,
   output bfm_pkg::cpl_job_t   job,
   output logic                job_valid,
   input  logic                job_ready,
   output logic [15:0]         tlp_drop_count
);
   localparam int aw = `TLBFM_MEM_AW;

   typedef enum logic [1:0] {st_hdr0, st_hdr1, st_payload, st_discard} parse_state_t;

   parse_state_t      state;
   tlp_pkg::tlp_hdr_t hdr_q;     // dwords 0 and 1 kept from the sop beat
   tlp_pkg::tlp_hdr_t hdr_cur;   // header as seen in the current beat
   logic [aw-1:0]     addr_idx;
   logic [aw-1:0]     wr_base;   // next pair index for payload beats
   logic              is_wr;
   logic              is_rd;
   logic              len_ok;
   logic              hdr_ok;
   logic              take;

   //--------------------------------------------------------------------
   // header decode
   //--------------------------------------------------------------------
   always_comb begin
      hdr_cur = hdr_q;
      if (state == st_hdr0) begin
         hdr_cur.fmt_type     = beat.data[31:24];
         hdr_cur.length       = beat.data[9:0];
         hdr_cur.requester_id = beat.data[63:48];
         hdr_cur.tag          = beat.data[47:40];
      end
      hdr_cur.address = beat.data[31:0];  // dword 2 sits low in the second beat
   end

   assign addr_idx = hdr_cur.address[2 +: aw];
   assign is_wr    = (hdr_cur.fmt_type == tlp_pkg::fmt_mwr32);
   assign is_rd    = (hdr_cur.fmt_type == tlp_pkg::fmt_mrd32);
   assign len_ok   = (hdr_cur.length != '0) &&
                     (hdr_cur.length <= 10'(`TLBFM_MAX_PAYLOAD));  // 0 means 1024
   assign hdr_ok   = (is_wr | is_rd) & len_ok;

   // read header beat waits for room in the job queue
   assign beat_ready = !((state == st_hdr1) && is_rd && !job_ready);
   assign take       = beat_valid & beat_ready;
   assign job_valid  = (state == st_hdr1) & is_rd & beat_valid;

   always_comb begin
      job.requester_id = hdr_cur.requester_id;
      job.tag          = hdr_cur.tag;
      job.length       = hdr_cur.length[3:0];
      job.index        = addr_idx;
      job.lower_addr   = hdr_cur.address[6:0];
   end

   //--------------------------------------------------------------------
   // packet FSM and drop counter
   //--------------------------------------------------------------------
   always_ff @(posedge avst64_clk or negedge bfm_reset_n) begin
      if (!bfm_reset_n) begin
         state          <= st_hdr0;
         mem_wr_valid   <= 1'b0;
         tlp_drop_count <= '0;
      end else begin
         mem_wr_valid <= 1'b0;
         if (take) begin
            case (state)
               st_hdr0: if (beat.sop) begin  // stray beats outside a packet are eaten
                  if (!hdr_ok) begin
                     tlp_drop_count <= tlp_drop_count + 16'd1;
                     if (!beat.eop) state <= st_discard;
                  end else if (!beat.eop) begin
                     state <= st_hdr1;
                  end
               end
               st_hdr1: begin
                  mem_wr_valid <= is_wr & ~beat.empty;  // data 0 in the upper dword
                  if (beat.eop)  state <= st_hdr0;
                  else if (is_wr) state <= st_payload;
                  else            state <= st_discard;
               end
               st_payload: begin
                  mem_wr_valid <= 1'b1;
                  if (beat.eop) state <= st_hdr0;
               end
               default: if (beat.eop) state <= st_hdr0;  // discard to end of packet
            endcase
         end
      end
   end

   // write pairs
   always_ff @(posedge avst64_clk) begin
      if (take) begin
         if (state == st_hdr0) hdr_q <= hdr_cur;
         if (state == st_hdr1) begin
            mem_wr.base  <= addr_idx - 1'b1;  // slot 1 hits the start index
            mem_wr.dw_en <= 2'b10;
            mem_wr.data  <= beat.data;
            wr_base      <= addr_idx + 1'b1;
         end
         if (state == st_payload) begin
            mem_wr.base  <= wr_base;
            mem_wr.dw_en <= {~beat.empty, 1'b1};
            mem_wr.data  <= beat.data;
            wr_base      <= wr_base + aw'(2);
         end
      end
   end

endmodule

/* tests/tlbfm_rp_vectors.svh */
/*
 * request table for the root port testbench
 * one row per request packet, applied in order
 * columns: fmt_type, byte address, length in dwords, expected drop
 */
`ifndef TLBFM_RP_VECTORS_SVH
`define TLBFM_RP_VECTORS_SVH

typedef struct packed {
   logic [7:0]  fmt;    // header byte 0
   logic [31:0] addr;   // byte address, dword aligned
   logic [9:0]  len;    // length field, 0 means 1024
   logic        drop;   // responder must consume and count it
} req_row_t;

localparam int num_req_rows = 30;

localparam req_row_t req_table [num_req_rows] = '{
   // writes of lengths 1 to 8, the last one wraps the memory end
   '{8'h40, 32'h0000_0000, 10'd1,  1'b0},
   '{8'h40, 32'h0000_0010, 10'd2,  1'b0},
   '{8'h40, 32'h0000_0020, 10'd3,  1'b0},
   '{8'h40, 32'h0000_0040, 10'd4,  1'b0},
   '{8'h40, 32'h1000_0060, 10'd5,  1'b0},  // upper address bits ignored
   '{8'h40, 32'h0000_0080, 10'd6,  1'b0},
   '{8'h40, 32'h0000_00A0, 10'd7,  1'b0},
   '{8'h40, 32'h0000_00F0, 10'd8,  1'b0},  // dwords 60..63 then 0..3
   // back to back reads, enough to fill the job queue
   '{8'h00, 32'h0000_00F0, 10'd8,  1'b0},
   '{8'h00, 32'h0000_0010, 10'd2,  1'b0},
   '{8'h00, 32'h0000_0020, 10'd3,  1'b0},
   '{8'h00, 32'h0000_0040, 10'd4,  1'b0},
   '{8'h00, 32'h1000_0060, 10'd5,  1'b0},
   '{8'h00, 32'h8000_0080, 10'd6,  1'b0},
   '{8'h00, 32'h0000_00A0, 10'd7,  1'b0},
   '{8'h00, 32'h0000_0000, 10'd1,  1'b0},
   '{8'h00, 32'h0000_00F8, 10'd8,  1'b0},
   // unsupported packets
   '{8'h44, 32'h0000_0100, 10'd1,  1'b1},  // config write type
   '{8'h40, 32'h0000_0000, 10'd9,  1'b1},  // write over max payload
   '{8'h00, 32'h0000_0020, 10'd12, 1'b1},  // read over max payload
   '{8'h20, 32'h0000_0040, 10'd2,  1'b1},  // 4-DW read type
   '{8'h00, 32'h0000_0000, 10'd0,  1'b1},  // length 0 is 1024
   // traffic after the drops
   '{8'h40, 32'h0000_0018, 10'd7,  1'b0},
   '{8'h00, 32'h0000_0000, 10'd8,  1'b0},  // would show the dropped write
   '{8'h00, 32'h0000_0014, 10'd1,  1'b0},
   '{8'h00, 32'h0000_00A4, 10'd3,  1'b0},
   '{8'h40, 32'h0000_00C0, 10'd8,  1'b0},
   '{8'h00, 32'h0000_00C4, 10'd7,  1'b0},
   '{8'h00, 32'h0000_00C0, 10'd8,  1'b0},
   '{8'h00, 32'h0000_0030, 10'd1,  1'b0}
};

`endif

/* tests/tlbfm_rp_tb.sv */
/*
 * root port responder testbench
 * drives request packets from the table, stalls tx at random, keeps
 * a dword reference memory and checks every completion beat
 */
`timescale 1ns/10ps
`include "tlbfm_settings.svh"

module tlbfm_rp_tb;

   `include "tlbfm_rp_vectors.svh"

   localparam int mem_words  = 1 << `TLBFM_MEM_AW;
   localparam int wait_limit = 2000;   // cycles per wait loop

   logic                avst64_clk;
   logic                bfm_reset_n;
   tlp_pkg::avst_beat_t rx_beat;
   logic                rx_valid;
   logic                rx_ready;
   tlp_pkg::avst_beat_t tx_beat;
   logic                tx_valid;
   logic                tx_ready;
   logic [15:0]         tlp_drop_count;

   integer              seed;
   logic [31:0]         ref_mem [mem_words];   // expected shared memory
   tlp_pkg::avst_beat_t exp_q [$];             // expected tx beats in order
   int                  drop_rows;

   tlbfm_rp u_dut (
      .avst64_clk     (avst64_clk),
      .bfm_reset_n    (bfm_reset_n),
      .rx_beat        (rx_beat),
      .rx_valid       (rx_valid),
      .rx_ready       (rx_ready),
      .tx_beat        (tx_beat),
      .tx_valid       (tx_valid),
      .tx_ready       (tx_ready),
      .tlp_drop_count (tlp_drop_count)
   );

   always #2 avst64_clk = ~avst64_clk;   // 4 ns period

   //----------------------------------------------------------------------
   // error reporting
   //----------------------------------------------------------------------
   task automatic stop_run();
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_error(input string what);
      $display("ERROR at %0t ns: %s", $time, what);
      stop_run();
   endtask

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] got);
      assert (got === exp) else begin
         $display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
         stop_run();
      end
   endtask

   // sampled on falling edges while the monitor pops on rising ones
   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while (exp_q.size() != 0) begin
         if (cycles == wait_limit)
            report_error("completions still outstanding after the timeout");
         @(negedge avst64_clk);
         cycles++;
      end
   endtask

   //----------------------------------------------------------------------
   // packet driver entered in a rising edge time step
   //----------------------------------------------------------------------
   task automatic send_packet(input int r);
      req_row_t            row;
      logic [31:0]         dws [$];   // request dwords on the wire
      logic [31:0]         cpl [$];   // expected completion dwords
      logic [15:0]         req_id;
      logic [7:0]          tag;
      tlp_pkg::avst_beat_t b;
      int                  idx;
      int                  n_data;
      int                  beats;
      int                  cycles;
      int                  j;
      int                  k;

      row    = req_table[r];
      req_id = 16'h0200 + 16'(r);
      tag    = 8'h40 + 8'(r);
      idx    = row.addr[`TLBFM_MEM_AW+1:2];
      n_data = row.fmt[6] ? int'(row.len) : 0;   // fmt bit 6 means payload follows
      dws.push_back({row.fmt, 14'h0, row.len});
      dws.push_back({req_id, tag, 8'hFF});
      dws.push_back(row.addr);
      for (k = 0; k < n_data; k++)
         dws.push_back($random(seed));

      if (!row.drop && row.fmt == tlp_pkg::fmt_mwr32) begin
         for (k = 0; k < n_data; k++)
            ref_mem[(idx + k) % mem_words] = dws[3 + k];   // wraps at the top
      end

      if (!row.drop && row.fmt == tlp_pkg::fmt_mrd32) begin
         cpl.push_back({tlp_pkg::fmt_cpld, 14'h0, row.len});
         cpl.push_back({`TLBFM_CPL_ID, 3'b000, 1'b0, 12'(row.len * 4)});  // byte count
         cpl.push_back({req_id, tag, 1'b0, row.addr[6:0]});
         for (k = 0; k < int'(row.len); k++)
            cpl.push_back(ref_mem[(idx + k) % mem_words]);
         beats = (cpl.size() + 1) / 2;
         for (j = 0; j < beats; j++) begin
            b.data[31:0]  = cpl[2*j];
            b.data[63:32] = (2*j + 1 < cpl.size()) ? cpl[2*j + 1] : 32'h0;
            b.sop         = (j == 0);
            b.eop         = (j == beats - 1);
            b.empty       = (2*j + 1 >= cpl.size());   // odd dword total
            exp_q.push_back(b);
         end
      end

      beats = (dws.size() + 1) / 2;
      for (j = 0; j < beats; j++) begin
         b.data[31:0]  = dws[2*j];
         b.data[63:32] = (2*j + 1 < dws.size()) ? dws[2*j + 1] : 32'h0;
         b.sop         = (j == 0);
         b.eop         = (j == beats - 1);
         b.empty       = (2*j + 1 >= dws.size());
         @(negedge avst64_clk);
         rx_beat  <= b;
         rx_valid <= 1'b1;
         cycles = 0;
         @(posedge avst64_clk);
         while (!rx_ready) begin   // beat held until taken
            if (cycles == wait_limit)
               report_error("rx_ready stayed low and a request beat was never taken");
            @(posedge avst64_clk);
            cycles++;
         end
      end
   endtask

   //----------------------------------------------------------------------
   // tx sink and monitor
   //----------------------------------------------------------------------
   always @(negedge avst64_clk) begin
      if (bfm_reset_n)
         tx_ready <= ({$random(seed)} % 3) != 0;   // ready two times in three
   end

   always @(posedge avst64_clk) begin : tx_monitor
      tlp_pkg::avst_beat_t exp;
      logic [63:0]         mask;
      if (bfm_reset_n && tx_valid && tx_ready) begin
         assert (exp_q.size() != 0) begin
            exp  = exp_q.pop_front();
            mask = exp.empty ? 64'h0000_0000_FFFF_FFFF : '1;   // upper dword unused
            check_value("tx_beat.data", exp.data & mask, tx_beat.data & mask);
            check_value("tx_beat.sop", exp.sop, tx_beat.sop);
            check_value("tx_beat.eop", exp.eop, tx_beat.eop);
            check_value("tx_beat.empty", exp.empty, tx_beat.empty);
         end else begin
            report_error("a completion beat arrived with no read outstanding");
         end
      end
   end

   //----------------------------------------------------------------------
   // main sequence
   //----------------------------------------------------------------------
   initial begin
      int i;
      int r;
      int cycles;
      avst64_clk  = 1'b0;
      bfm_reset_n = 1'b0;
      rx_beat     = '0;
      rx_valid    = 1'b0;
      tx_ready    = 1'b1;
      seed        = 15;
      drop_rows   = 0;
      for (i = 0; i < mem_words; i++)
         ref_mem[i] = 'x;   // reads of unwritten dwords show up as X

      for (r = 0; r < num_req_rows; r++) begin
         if (req_table[r].drop)
            drop_rows++;
      end

      repeat (16) @(posedge avst64_clk);
      @(negedge avst64_clk);
      bfm_reset_n <= 1'b1;
      @(posedge avst64_clk);
      check_value("tx_valid", 64'd0, tx_valid);
      check_value("tlp_drop_count", 64'd0, tlp_drop_count);
      cycles = 0;
      while (!rx_ready) begin
         if (cycles == 20)
            report_error("rx_ready did not rise after reset");
         @(posedge avst64_clk);
         cycles++;
      end

      for (r = 0; r < num_req_rows; r++) begin
         if (req_table[r].fmt == tlp_pkg::fmt_mwr32) begin
            // no write lands under a read still being answered
            @(negedge avst64_clk);
            rx_valid <= 1'b0;
            wait_drain();
            @(posedge avst64_clk);
         end
         send_packet(r);
      end

      @(negedge avst64_clk);
      rx_valid <= 1'b0;
      wait_drain();
      repeat (32) @(negedge avst64_clk);   // a stray completion would hit the monitor
      check_value("tlp_drop_count", 64'(drop_rows), tlp_drop_count);
      check_value("rx_ready", 64'd1, rx_ready);
      $display("TEST OK");
      $finish;
   end

endmodule

/* tlbfm_rp.f */
+incdir+logic
+incdir+tests
logic/tlp_pkg.sv
logic/bfm_pkg.sv
logic/tlp_fifo.sv
logic/tlp_rx_parser.sv
logic/bfm_shmem.sv
logic/cpl_tx_builder.sv
logic/tlbfm_rp.sv
tests/tlbfm_rp_tb.sv
